/* dv/alu_stage_cases.txt */
// opcode funct3 funct7 rd a b pc offset, then the expected result, taken and target.
// the result is a+offset for LOAD and STORE, pc+4 for JAL and a+b for BRANCH; target is pc+offset.
33 0 00 01 00000007 00000005 00001000 00000000 0000000c 0 00001000
33 0 20 02 00000005 00000007 00001004 00000000 fffffffe 0 00001004
33 1 00 03 00000001 00000024 00001008 00000000 00000010 0 00001008
33 2 00 04 ffffffff 00000001 0000100c 00000000 00000001 0 0000100c
33 3 00 05 ffffffff 00000001 00001010 00000000 00000000 0 00001010
33 4 00 06 ff00ff00 0f0f0f0f 00001014 00000000 f00ff00f 0 00001014
33 5 00 07 80000000 00000004 00001018 00000000 08000000 0 00001018
33 5 20 08 80000000 00000004 0000101c 00000000 f8000000 0 0000101c
33 6 00 09 12340000 00005678 00001020 00000000 12345678 0 00001020
33 7 00 0a f0f0f0f0 ff00ff00 00001024 00000000 f000f000 0 00001024
13 0 7f 0b 00000010 00000000 00001028 ffffffff 0000000f 0 00001027
13 5 20 0c ffffff00 00000000 0000102c 00000404 fffffff0 0 00001430
13 2 00 0d 00000003 00000000 00001030 00000005 00000001 0 00001035
17 0 00 0e 00000000 00000000 00002000 00012000 00014000 0 00014000
6f 0 00 01 00000000 00000000 00003000 00000100 00003004 0 00003100
6f 0 00 05 00000000 00000000 00003010 fffffff0 00003014 0 00003000
63 0 00 00 00000005 00000005 00004000 00000010 0000000a 1 00004010
63 0 00 00 00000005 00000006 00004004 00000010 0000000b 0 00004014
63 1 00 00 00000005 00000006 00004008 fffffff8 0000000b 1 00004000
63 4 00 00 fffffffe 00000001 0000400c 00000020 ffffffff 1 0000402c
63 5 00 00 fffffffe 00000001 00004010 00000020 ffffffff 0 00004030
63 5 00 00 00000007 00000007 00004014 00000008 0000000e 1 0000401c
03 2 00 0f 00008000 00000000 00005000 00000004 00008004 0 00005004
03 0 00 10 00008000 00000000 00005004 fffffffc 00007ffc 0 00005000
23 2 00 00 00009000 cafef00d 00005008 00000010 00009010 0 00005018
23 0 00 00 00009000 000000a5 0000500c 00000001 00009001 0 0000500d

/* vlog.f */
+incdir+logic
logic/core_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/alu_stage.sv
dv/alu_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module alu_stage_tb -o alu_stage_sim
./obj_dir/alu_stage_sim | tee sim.log
if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

/* dv/alu_stage_tb.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module alu_stage_tb;

  import core_pkg::*;

  localparam int NUM_COLS   = 11;
  localparam int MAX_CASES  = 64;
  localparam int COL_OPCODE = 0;
  localparam int COL_F3     = 1;
  localparam int COL_F7     = 2;
  localparam int COL_RD     = 3;
  localparam int COL_A      = 4;
  localparam int COL_B      = 5;
  localparam int COL_PC     = 6;
  localparam int COL_OFFSET = 7;
  localparam int COL_RESULT = 8;
  localparam int COL_TAKEN  = 9;
  localparam int COL_TARGET = 10;

  logic clk_i = 1'b0;
  logic rst_i, valid_i, mem_stall_i;
  data_t data_a_i, data_b_i, offset_i;
  addr_t pc_i;
  opcode_t opcode_i;
  funct3_t funct3_i;
  funct7_t funct7_i;
  reg_idx_t rd_i;
  logic is_instr_wbalu_o, instr_finishes_o, branch_taken_o, is_jump_o;
  reg_idx_t wr_reg_o, mem_wr_reg_o;
  data_t data_to_reg_o, mem_alu_result_o, mem_rs2_data_o;
  addr_t pc_branch_offset_o, jump_address_o;
  logic mem_valid_o, mem_reg_wr_en_o, mem_is_load_o, mem_is_store_o;
  access_size_t mem_access_size_o;

  logic [`DATA_WIDTH-1:0] case_mem [0:NUM_COLS*MAX_CASES-1];
  logic [`DATA_WIDTH-1:0] held [0:7];  // mem_ outputs seen before a stall.
  int num_cases, case_idx, case_errors, error_count, tests_run, tests_failed;
  int cycle_count = 0;
  int cycle_limit = 200;

  alu_stage alu_stage_i (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("run stopped after %0d cycles, the tests did not finish in time", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] case_field(input int idx, input int col);
    return case_mem[idx*NUM_COLS + col];
  endfunction

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @%0t: case %0d %s is %h, expected %h", $time, case_idx, what, got, exp);
      error_count++;
      case_errors++;
    end
  endtask

  task automatic drive_case(input int idx, input logic valid);
    valid_i  <= valid;
    opcode_i <= opcode_t'(case_field(idx, COL_OPCODE));
    funct3_i <= funct3_t'(case_field(idx, COL_F3));
    funct7_i <= funct7_t'(case_field(idx, COL_F7));
    rd_i     <= reg_idx_t'(case_field(idx, COL_RD));
    data_a_i <= case_field(idx, COL_A);
    data_b_i <= case_field(idx, COL_B);
    pc_i     <= case_field(idx, COL_PC);
    offset_i <= case_field(idx, COL_OFFSET);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (case_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (case_errors == 0) ? "pass" : "fail");
    case_errors = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One case with valid high, plus the memory register for LOAD and STORE
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_case(input int idx);
    opcode_t op;
    logic [31:0] pc, exp_res;
    logic exp_taken, is_mem;
    int stalls;
    case_idx  = idx;
    op        = opcode_t'(case_field(idx, COL_OPCODE));
    pc        = case_field(idx, COL_PC);
    exp_res   = case_field(idx, COL_RESULT);
    exp_taken = (case_field(idx, COL_TAKEN) != 32'd0);
    is_mem    = (op == OP_LOAD) || (op == OP_STORE);
    stalls    = is_mem ? int'($urandom % 32'd3) : 0;
    @(posedge clk_i);
    drive_case(idx, 1'b1);
    mem_stall_i <= (stalls > 0);
    @(negedge clk_i);
    check_word("branch_taken", 32'(branch_taken_o), 32'(exp_taken));
    check_word("is_jump", 32'(is_jump_o), 32'(op == OP_JAL));
    if ((op == OP_R) || (op == OP_IMM) || (op == OP_AUIPC)) begin
      check_word("data_to_reg", data_to_reg_o, exp_res);
      check_word("is_instr_wbalu", 32'(is_instr_wbalu_o), 32'd1);
      check_word("instr_finishes", 32'(instr_finishes_o), 32'd1);
      check_word("wr_reg", 32'(wr_reg_o), case_field(idx, COL_RD));
    end
    if (op == OP_BRANCH) begin
      check_word("pc_branch_offset", pc_branch_offset_o, case_field(idx, COL_TARGET));
    end
    if (op == OP_JAL) begin
      check_word("link data_to_reg", data_to_reg_o, pc + 32'd4);
      check_word("jump_address", jump_address_o, case_field(idx, COL_TARGET));
    end
    if (is_mem) begin
      held[0] = 32'(mem_valid_o);
      held[1] = 32'(mem_reg_wr_en_o);
      held[2] = 32'(mem_is_load_o);
      held[3] = 32'(mem_is_store_o);
      held[4] = mem_alu_result_o;
      held[5] = mem_rs2_data_o;
      held[6] = 32'(mem_wr_reg_o);
      held[7] = 32'(mem_access_size_o);
      for (int s = 0; s < stalls; s++) begin
        @(posedge clk_i);
        if (s == stalls - 1) begin
          mem_stall_i <= 1'b0;
        end
        @(negedge clk_i);
        check_word("stalled mem_valid", 32'(mem_valid_o), held[0]);
        check_word("stalled mem_reg_wr_en", 32'(mem_reg_wr_en_o), held[1]);
        check_word("stalled mem_is_load", 32'(mem_is_load_o), held[2]);
        check_word("stalled mem_is_store", 32'(mem_is_store_o), held[3]);
        check_word("stalled mem_alu_result", mem_alu_result_o, held[4]);
        check_word("stalled mem_rs2_data", mem_rs2_data_o, held[5]);
        check_word("stalled mem_wr_reg", 32'(mem_wr_reg_o), held[6]);
        check_word("stalled mem_access_size", 32'(mem_access_size_o), held[7]);
      end
      @(posedge clk_i);
      valid_i <= 1'b0;
      @(negedge clk_i);
      check_word("mem_valid", 32'(mem_valid_o), 32'd1);
      check_word("mem_is_load", 32'(mem_is_load_o), 32'(op == OP_LOAD));
      check_word("mem_is_store", 32'(mem_is_store_o), 32'(op == OP_STORE));
      check_word("mem_reg_wr_en", 32'(mem_reg_wr_en_o), 32'(op == OP_LOAD));
      check_word("mem_alu_result", mem_alu_result_o, exp_res);
      check_word("mem_rs2_data", mem_rs2_data_o, case_field(idx, COL_B));
      check_word("mem_wr_reg", 32'(mem_wr_reg_o), case_field(idx, COL_RD));
      check_word("mem_access_size", 32'(mem_access_size_o),
                 (case_field(idx, COL_F3) == 32'd0) ? 32'(BYTE) : 32'(WORD));
    end
    finish_test($sformatf("case %0d opcode %h", idx, op));
  endtask

  task automatic run_gated_case(input int idx);
    case_idx = idx;
    @(posedge clk_i);
    drive_case(idx, 1'b0);
    mem_stall_i <= 1'b0;
    @(negedge clk_i);
    check_word("gated is_instr_wbalu", 32'(is_instr_wbalu_o), 32'd0);
    check_word("gated instr_finishes", 32'(instr_finishes_o), 32'd0);
    check_word("gated branch_taken", 32'(branch_taken_o), 32'd0);
    check_word("gated is_jump", 32'(is_jump_o), 32'd0);
    @(posedge clk_i);
    @(negedge clk_i);
    check_word("gated mem_valid", 32'(mem_valid_o), 32'd0);
    check_word("gated mem_reg_wr_en", 32'(mem_reg_wr_en_o), 32'd0);
    finish_test($sformatf("gated case %0d", idx));
  endtask

  initial begin : run
    rst_i = 1'b0;
    valid_i = 1'b0;
    mem_stall_i = 1'b0;
    data_a_i = '0;
    data_b_i = '0;
    offset_i = '0;
    pc_i = '0;
    opcode_i = '0;
    funct3_i = '0;
    funct7_i = '0;
    rd_i = '0;
    error_count = 0;
    case_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(32'hb7bb));
    for (int i = 0; i < NUM_COLS*MAX_CASES; i++) begin
      case_mem[i] = 32'hdead_0000 ^ i;  // no real opcode is this large.
    end
    $readmemh("dv/alu_stage_cases.txt", case_mem);
    num_cases = 0;
    while ((num_cases < MAX_CASES) && (case_field(num_cases, COL_OPCODE) <= 32'h7f)) begin
      num_cases++;
    end
    cycle_limit = 4*num_cases + 200;
    if (num_cases == 0) begin
      $display("no cases were read from dv/alu_stage_cases.txt");
      error_count++;
    end

    repeat (10) @(posedge clk_i);
    rst_i <= 1'b1;
    @(negedge clk_i);
    case_idx = -1;
    check_word("reset mem_valid", 32'(mem_valid_o), 32'd0);
    check_word("reset mem_reg_wr_en", 32'(mem_reg_wr_en_o), 32'd0);
    check_word("reset mem_is_load", 32'(mem_is_load_o), 32'd0);
    check_word("reset mem_is_store", 32'(mem_is_store_o), 32'd0);
    finish_test("reset");

    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    for (int i = 0; i < num_cases; i++) begin
      run_gated_case(i);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if ((error_count == 0) && (tests_failed == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : alu_stage_tb

/* logic/alu_stage.sv */
`timescale 1ns/10ps

module alu_stage (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  logic                   mem_stall_i,
  input  core_pkg::data_t        data_a_i,
  input  core_pkg::data_t        data_b_i,
  input  core_pkg::data_t        offset_i,
  input  core_pkg::addr_t        pc_i,
  input  core_pkg::opcode_t      opcode_i,
  input  core_pkg::funct3_t      funct3_i,
  input  core_pkg::funct7_t      funct7_i,
  input  core_pkg::reg_idx_t     rd_i,
  output logic                   is_instr_wbalu_o,
  output logic                   instr_finishes_o,
  output logic                   branch_taken_o,
  output logic                   is_jump_o,
  output core_pkg::reg_idx_t     wr_reg_o,
  output core_pkg::data_t        data_to_reg_o,
  output core_pkg::addr_t        pc_branch_offset_o,
  output core_pkg::addr_t        jump_address_o,
  output logic                   mem_valid_o,
  output logic                   mem_reg_wr_en_o,
  output logic                   mem_is_load_o,
  output logic                   mem_is_store_o,
  output core_pkg::data_t        mem_alu_result_o,
  output core_pkg::data_t        mem_rs2_data_o,
  output core_pkg::reg_idx_t     mem_wr_reg_o,
  output core_pkg::access_size_t mem_access_size_o
);

  import core_pkg::*;

  logic         is_r;
  logic         is_imm;
  logic         is_load;
  logic         is_store;
  logic         is_branch;
  logic         is_jal;
  logic         is_auipc;
  logic         branch_en;
  data_t        alu_a;
  data_t        alu_b;
  data_t        alu_result;
  addr_t        target;
  access_size_t access_size_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcode decode and strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign is_r      = (opcode_i == OP_R);
  assign is_imm    = (opcode_i == OP_IMM);
  assign is_load   = (opcode_i == OP_LOAD);
  assign is_store  = (opcode_i == OP_STORE);
  assign is_branch = (opcode_i == OP_BRANCH);
  assign is_jal    = (opcode_i == OP_JAL);
  assign is_auipc  = (opcode_i == OP_AUIPC);

  assign is_instr_wbalu_o = valid_i && (is_r || is_imm || is_jal || is_auipc);
  assign instr_finishes_o = valid_i && (is_r || is_imm || is_jal || is_auipc || is_branch);
  assign is_jump_o        = valid_i && is_jal;
  assign branch_en        = valid_i && is_branch;

  // loads and stores move on to memory and finish there.
  assign access_size_d = (funct3_i == 3'b000) ? BYTE : WORD;

  always_comb begin : steer
    alu_a = data_a_i;
    alu_b = data_b_i;
    case (opcode_i)
      OP_JAL: begin
        alu_a = data_t'(pc_i);
        alu_b = data_t'(4);  // link address is pc + 4.
      end
      OP_AUIPC: begin
        alu_a = data_t'(pc_i);
        alu_b = offset_i;
      end
      OP_IMM, OP_LOAD, OP_STORE: begin
        alu_b = offset_i;
      end
      default: begin
        alu_b = data_b_i;
      end
    endcase
  end

  alu alu_i (
    .opcode_i (opcode_i),
    .funct3_i (funct3_i),
    .funct7_i (funct7_i),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  branch_unit branch_unit_i (
    .branch_i (branch_en),
    .funct3_i (funct3_i),
    .a_i      (data_a_i),
    .b_i      (data_b_i),
    .pc_i     (pc_i),
    .offset_i (offset_i),
    .taken_o  (branch_taken_o),
    .target_o (target)
  );

  assign wr_reg_o           = rd_i;
  assign data_to_reg_o      = alu_result;
  assign pc_branch_offset_o = target;
  assign jump_address_o     = target;  // JAL uses the same pc-relative target.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute/memory register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin : ctrl_regs
    if (!rst_i) begin
      mem_valid_o     <= 1'b0;
      mem_reg_wr_en_o <= 1'b0;
      mem_is_load_o   <= 1'b0;
      mem_is_store_o  <= 1'b0;
    end else if (!mem_stall_i) begin
      mem_valid_o     <= valid_i && (is_load || is_store);
      mem_reg_wr_en_o <= valid_i && is_load;
      mem_is_load_o   <= is_load;
      mem_is_store_o  <= is_store;
    end
  end

  always_ff @(posedge clk_i) begin : data_regs
    if (!mem_stall_i) begin
      mem_alu_result_o  <= alu_result;  // address of the access.
      mem_rs2_data_o    <= data_b_i;
      mem_wr_reg_o      <= rd_i;
      mem_access_size_o <= access_size_d;
    end
  end

  a_load_store_excl : assert property (@(posedge clk_i) disable iff (!rst_i)
    !(mem_is_load_o && mem_is_store_o))
    else $error("alu_stage: memory op flagged as both load and store.");

endmodule : alu_stage

/* logic/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
  input  logic              branch_i,
  input  core_pkg::funct3_t funct3_i,
  input  core_pkg::data_t   a_i,
  input  core_pkg::data_t   b_i,
  input  core_pkg::addr_t   pc_i,
  input  core_pkg::data_t   offset_i,
  output logic              taken_o,
  output core_pkg::addr_t   target_o
);

  import core_pkg::*;

  logic is_equal;
  logic is_less;

  assign is_equal = (a_i == b_i);
  assign is_less  = ($signed(a_i) < $signed(b_i));

  always_comb begin : decide
    taken_o = 1'b0;
    if (branch_i) begin
      case (funct3_i)
        F3_BEQ:  taken_o = is_equal;
        F3_BNE:  taken_o = !is_equal;
        F3_BLT:  taken_o = is_less;
        F3_BGE:  taken_o = !is_less;
        default: taken_o = 1'b0;
      endcase
    end
  end

  // branches and JAL both target pc plus the sign-extended offset.
  assign target_o = pc_i + addr_t'(offset_i);

  always_comb begin : check_taken
    if (!branch_i) begin
      assert final (!taken_o)
        else $error("branch_unit: taken raised without a valid branch.");
    end
  end

endmodule : branch_unit

/* logic/alu.sv */
`timescale 1ns/10ps

module alu (
  input  core_pkg::opcode_t opcode_i,
  input  core_pkg::funct3_t funct3_i,
  input  core_pkg::funct7_t funct7_i,
  input  core_pkg::data_t   a_i,
  input  core_pkg::data_t   b_i,
  output core_pkg::data_t   result_o
);

  import core_pkg::*;

  logic [4:0] shamt;
  logic       use_funct3;
  logic       alt_op;

  assign shamt      = b_i[4:0];
  assign use_funct3 = (opcode_i == OP_R) || (opcode_i == OP_IMM);  // other classes just add.
  assign alt_op     = funct7_i[5];  // selects sub and sra.

  always_comb begin : compute
    result_o = a_i + b_i;
    if (use_funct3) begin
      case (funct3_i)
        3'b000: begin
          // addi has immediate bits in funct7, so only R-type may subtract.
          if ((opcode_i == OP_R) && alt_op) begin
            result_o = a_i - b_i;
          end
        end
        3'b001: begin
          result_o = a_i << shamt;
        end
        3'b010: begin
          result_o = data_t'($signed(a_i) < $signed(b_i));
        end
        3'b011: begin
          result_o = data_t'(a_i < b_i);
        end
        3'b100: begin
          result_o = a_i ^ b_i;
        end
        3'b101: begin
          if (alt_op) begin
            result_o = $signed(a_i) >>> shamt;
          end else begin
            result_o = a_i >> shamt;
          end
        end
        3'b110: begin
          result_o = a_i | b_i;
        end
        default: begin
          result_o = a_i & b_i;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks on the decoded fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : check_funct7
    if (opcode_i == OP_R) begin
      assert final ((funct7_i == 7'h00) || (funct7_i == 7'h20))
        else $error("alu: funct7 %h is not legal for an R-type op.", funct7_i);
    end
  end

endmodule : alu

/* logic/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [`DATA_WIDTH-1:0]    data_t;
  typedef logic [`ADDR_WIDTH-1:0]    addr_t;
  typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [`OPCODE_WIDTH-1:0]  opcode_t;
  typedef logic [2:0]                funct3_t;
  typedef logic [6:0]                funct7_t;
  typedef logic                      access_size_t;

  localparam access_size_t BYTE = 1'b0;
  localparam access_size_t WORD = 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32I major opcodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam opcode_t OP_R      = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;

  // branch conditions, unsigned compares are not supported.
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;
  localparam funct3_t F3_BLT = 3'b100;
  localparam funct3_t F3_BGE = 3'b101;

endpackage : core_pkg

/* logic/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths of the core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// operand and result word.
`define DATA_WIDTH    32
// pc and branch or jump target.
`define ADDR_WIDTH    32
// destination register index.
`define REG_IDX_WIDTH 5
// major opcode field of the instruction.
`define OPCODE_WIDTH  7

`endif
